// File: vlog.f
design/alu_pkg.sv
design/alu_step_if.sv
design/alu_sequencer.sv
design/alu_datapath.sv
design/alu_top.sv
testbench/alu_checker.sv
testbench/alu_tb.sv

// File: testbench/alu_tb.sv
// Testbench top for the ALU; drives directed and random operations under random back-pressure
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
  import alu_pkg::*;

  localparam int clk_period = 8;
  localparam int num_random = 300;
  localparam int wait_limit = 200;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  logic      in_ready;
  alu_op_e   op;
  logic      sgn;
  alu_word_t a;
  alu_word_t b;
  logic      out_valid;
  logic      out_ready;
  alu_word_t result;
  logic      error;

  int   value_errors;
  int   protocol_errors;
  int   pending;
  int   timeout_errors;
  int   seed;
  int   waited;
  logic timed_out;
  logic draining;

  alu_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .i_op        (op),
    .i_signed    (sgn),
    .i_a         (a),
    .i_b         (b),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready),
    .o_result    (result),
    .o_error     (error)
  );

  alu_checker u_checker (
    .clk               (clk),
    .rst_n             (rst_n),
    .i_in_valid        (in_valid),
    .i_in_ready        (in_ready),
    .i_op              (op),
    .i_signed          (sgn),
    .i_a               (a),
    .i_b               (b),
    .i_out_valid       (out_valid),
    .i_out_ready       (out_ready),
    .i_result          (result),
    .i_error           (error),
    .o_value_errors    (value_errors),
    .o_protocol_errors (protocol_errors),
    .o_pending         (pending)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Advance to the next falling edge with fresh back-pressure
  task automatic next_cycle();
    int r;
    @(negedge clk);
    r = $random(seed);
    out_ready = draining ? 1'b1 : (r[0] | r[1]);
  endtask

  // Mostly random words, with corner values mixed in
  function automatic alu_word_t pick_operand();
    int r;
    r = $random(seed);
    case (r[3:0])
      4'd0:    return 16'h0000;
      4'd1:    return 16'h8000;
      4'd2:    return 16'hffff;
      4'd3:    return 16'h0001;
      4'd4:    return 16'h7fff;
      default: return r[31:16];
    endcase
  endfunction

  task automatic send_op(input alu_op_e t_op, input logic t_sgn,
                         input alu_word_t t_a, input alu_word_t t_b);
    int count;
    count = 0;
    if (!timed_out) begin
      while (!in_ready && count < wait_limit) begin
        next_cycle();
        count++;
      end
      if (!in_ready) begin
        $display("Timeout at %0t: o_in_ready stayed low for %0d cycles", $time, wait_limit);
        timeout_errors++;
        timed_out = 1'b1;
      end else begin
        in_valid = 1'b1;
        op       = t_op;
        sgn      = t_sgn;
        a        = t_a;
        b        = t_b;
        next_cycle();
        in_valid = 1'b0;
      end
    end
  endtask

  task automatic send_random();
    int r;
    r = $random(seed);
    send_op(alu_op_e'(r[1:0]), r[2], pick_operand(), pick_operand());
    // Occasional idle gap between operations
    if (r[5:3] == 3'd0) begin
      next_cycle();
    end
  endtask

  initial begin
    seed           = 46;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    op             = OP_ADD;
    sgn            = 1'b0;
    a              = '0;
    b              = '0;
    out_ready      = 1'b0;
    draining       = 1'b0;
    timed_out      = 1'b0;
    timeout_errors = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    next_cycle();

    // Wrap-around, both multiply modes, all divide sign cases and divide by zero
    send_op(OP_ADD, 1'b0, 16'hffff, 16'h0001);
    send_op(OP_SUB, 1'b0, 16'h0000, 16'h0001);
    send_op(OP_MUL, 1'b0, 16'hfffe, 16'h0003);
    send_op(OP_MUL, 1'b1, 16'hfffe, 16'h0003);
    send_op(OP_DIV, 1'b0, 16'd1000, 16'd7);
    send_op(OP_DIV, 1'b1, 16'd100, 16'd7);
    send_op(OP_DIV, 1'b1, 16'hff9c, 16'd7);
    send_op(OP_DIV, 1'b1, 16'd100, 16'hfff9);
    send_op(OP_DIV, 1'b1, 16'hff9c, 16'hfff9);
    send_op(OP_DIV, 1'b1, 16'h8000, 16'hffff);
    send_op(OP_DIV, 1'b0, 16'h1234, 16'h0000);
    send_op(OP_DIV, 1'b1, 16'h8000, 16'h0000);

    repeat (num_random) send_random();

    // Let the last result out
    draining = 1'b1;
    waited   = 0;
    while (!timed_out && pending != 0 && waited < wait_limit) begin
      next_cycle();
      waited++;
    end
    if (!timed_out && pending != 0) begin
      $display("Timeout at %0t: %0d results never came out", $time, pending);
      timeout_errors++;
    end
    next_cycle();

    $display("Errors: value %0d, protocol %0d, timeout %0d",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/alu_checker.sv
// Watches the ALU ports, predicts each result and compares it when the result is taken
`timescale 1ns/1ps
`default_nettype none

module alu_checker (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_in_valid,
  input  logic               i_in_ready,
  input  alu_pkg::alu_op_e   i_op,
  input  logic               i_signed,
  input  alu_pkg::alu_word_t i_a,
  input  alu_pkg::alu_word_t i_b,
  input  logic               i_out_valid,
  input  logic               i_out_ready,
  input  alu_pkg::alu_word_t i_result,
  input  logic               i_error,
  output int                 o_value_errors,
  output int                 o_protocol_errors,
  output int                 o_pending
);
  import alu_pkg::*;

  typedef struct packed {
    alu_op_e   op;
    logic      sgn;
    alu_word_t a;
    alu_word_t b;
    alu_word_t result;
    logic      error;
    int        latency;
  } expect_t;

  expect_t            exp_q[$];
  expect_t            head;
  expect_t            entry;
  logic [alu_width:0] ref_val;
  logic               busy;
  int                 cycles;
  logic               hold_pending;
  alu_word_t          hold_result;
  logic               hold_error;
  logic               reset_checked;

  // Expected error flag above the expected result word
  // Signed divide truncates toward zero in 32-bit arithmetic
  function automatic logic [alu_width:0] ref_result(alu_op_e op, logic sgn,
                                                    alu_word_t a, alu_word_t b);
    logic [2*alu_width-1:0] prod;
    int                     sa;
    int                     sb;
    int                     q;
    case (op)
      OP_ADD: return {1'b0, alu_word_t'(a + b)};
      OP_SUB: return {1'b0, alu_word_t'(a - b)};
      OP_MUL: begin
        prod = {{alu_width{1'b0}}, a} * {{alu_width{1'b0}}, b};
        return {1'b0, prod[alu_width-1:0]};
      end
      default: begin
        if (b == '0) begin
          return {1'b1, {alu_width{1'b0}}};
        end else if (!sgn) begin
          return {1'b0, alu_word_t'(a / b)};
        end
        sa = $signed(a);
        sb = $signed(b);
        q  = sa / sb;
        return {1'b0, q[alu_width-1:0]};
      end
    endcase
  endfunction

  // Cycles from the accepting edge to o_out_valid
  function automatic int ref_latency(alu_op_e op, logic sgn, alu_word_t b);
    if (op == OP_DIV && b == '0) begin
      return 1;
    end else if (op == OP_DIV) begin
      return sgn ? 21 : 19;
    end else if (op == OP_MUL) begin
      return 18;
    end
    return 2;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      busy              = 1'b0;
      cycles            = 0;
      hold_pending      = 1'b0;
      reset_checked     = 1'b0;
      o_value_errors    = 0;
      o_protocol_errors = 0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (!i_in_ready || i_out_valid) begin
          o_protocol_errors++;
          $display("Protocol error at %0t: after reset o_in_ready=%0b o_out_valid=%0b",
                   $time, i_in_ready, i_out_valid);
        end
      end
      // A stalled result keeps its value
      if (hold_pending && (!i_out_valid || i_result !== hold_result ||
                           i_error !== hold_error)) begin
        o_protocol_errors++;
        $display("Protocol error at %0t: result changed while i_out_ready was low", $time);
      end
      hold_pending = 1'b0;
      if (busy) begin
        cycles++;
        if (i_out_valid) begin
          busy = 1'b0;
          if (exp_q.size() > 0 && cycles != exp_q[0].latency) begin
            o_value_errors++;
            $display("FAILED at %0t: %s signed=%0b a=%h b=%h valid after %0d cycles, expected %0d",
                     $time, exp_q[0].op.name(), exp_q[0].sgn, exp_q[0].a, exp_q[0].b,
                     cycles, exp_q[0].latency);
          end
        end
      end
      if (i_out_valid) begin
        if (exp_q.size() == 0) begin
          o_protocol_errors++;
          $display("Protocol error at %0t: o_out_valid high with no operation pending", $time);
        end else if (i_out_ready) begin
          head = exp_q.pop_front();
          if (i_result !== head.result || i_error !== head.error) begin
            o_value_errors++;
            $display("FAILED at %0t: %s signed=%0b a=%h b=%h expected %h err %0b, got %h err %0b",
                     $time, head.op.name(), head.sgn, head.a, head.b, head.result, head.error,
                     i_result, i_error);
          end
        end else begin
          hold_pending = 1'b1;
          hold_result  = i_result;
          hold_error   = i_error;
        end
      end
      if (i_in_ready && exp_q.size() != 0) begin
        o_protocol_errors++;
        $display("Protocol error at %0t: o_in_ready high while a result is pending", $time);
      end
      if (i_in_valid && i_in_ready) begin
        ref_val        = ref_result(i_op, i_signed, i_a, i_b);
        entry.op       = i_op;
        entry.sgn      = i_signed;
        entry.a        = i_a;
        entry.b        = i_b;
        entry.result   = ref_val[alu_width-1:0];
        entry.error    = ref_val[alu_width];
        entry.latency  = ref_latency(i_op, i_signed, i_b);
        exp_q.push_back(entry);
        busy   = 1'b1;
        cycles = 0;
      end
    end
    o_pending = exp_q.size();
  end

endmodule

`default_nettype wire

// File: design/alu_top.sv
// Top level of the multi-cycle ALU with valid/ready handshakes on input and output
`timescale 1ns/1ps
`default_nettype none

module alu_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_in_valid,
  output logic               o_in_ready,
  input  alu_pkg::alu_op_e   i_op,
  input  logic               i_signed,
  input  alu_pkg::alu_word_t i_a,
  input  alu_pkg::alu_word_t i_b,
  output logic               o_out_valid,
  input  logic               i_out_ready,
  output alu_pkg::alu_word_t o_result,
  output logic               o_error
);

  // Strobes from control to data path
  alu_step_if step_if (
    .clk   (clk),
    .rst_n (rst_n)
  );

  alu_sequencer u_sequencer (
    .i_in_valid  (i_in_valid),
    .i_op        (i_op),
    .i_signed    (i_signed),
    .i_a         (i_a),
    .i_b         (i_b),
    .i_out_ready (i_out_ready),
    .o_in_ready  (o_in_ready),
    .o_out_valid (o_out_valid),
    .o_error     (o_error),
    .step        (step_if.ctrl)
  );

  alu_datapath u_datapath (
    .i_a      (i_a),
    .i_b      (i_b),
    .step     (step_if.dp),
    .o_result (o_result)
  );

endmodule

`default_nettype wire

// File: design/alu_datapath.sv
// ALU data path with operand and result registers around one shared adder, driven by step strobes
`timescale 1ns/1ps
`default_nettype none

module alu_datapath (
  input  alu_pkg::alu_word_t i_a,
  input  alu_pkg::alu_word_t i_b,
  alu_step_if.dp             step,
  output alu_pkg::alu_word_t o_result
);
  import alu_pkg::*;

  // Upper half holds the partial remainder during divide
  logic [2*alu_width-1:0] a_q;
  alu_word_t              b_q;
  alu_word_t              result_q;

  alu_word_t add_x;
  alu_word_t add_y;
  logic      add_cin;
  alu_word_t add_sum;
  logic      add_cout;
  logic      divides;

  assign {add_cout, add_sum} = {1'b0, add_x} + {1'b0, add_y} + {{alu_width{1'b0}}, add_cin};

  // A bit shifted out of the remainder means it already exceeds the divisor
  assign divides = add_cout | a_q[2*alu_width-1];

  // Adder input selection for the active strobe
  // Subtraction and negation use inverted input plus carry in
  always_comb begin
    add_x   = '0;
    add_y   = '0;
    add_cin = 1'b0;
    if (step.add_en) begin
      add_x = a_q[alu_width-1:0];
      add_y = b_q;
    end else if (step.sub_en) begin
      add_x   = a_q[alu_width-1:0];
      add_y   = ~b_q;
      add_cin = 1'b1;
    end else if (step.mul_en) begin
      add_x = result_q;
      add_y = b_q;
    end else if (step.div_en) begin
      // Trial subtraction of the divisor from the shifted remainder
      add_x   = a_q[2*alu_width-2:alu_width-1];
      add_y   = ~b_q;
      add_cin = 1'b1;
    end else if (step.flip_a_en) begin
      add_x   = ~a_q[alu_width-1:0];
      add_cin = 1'b1;
    end else if (step.flip_b_en) begin
      add_x   = ~b_q;
      add_cin = 1'b1;
    end else if (step.negate_en) begin
      add_x   = ~result_q;
      add_cin = 1'b1;
    end
  end

  always_ff @(posedge step.clk) begin
    if (step.load) begin
      a_q <= {{alu_width{1'b0}}, i_a};
    end else if (step.flip_a_en) begin
      // Magnitude only for a negative operand
      if (a_q[alu_width-1]) begin
        a_q[alu_width-1:0] <= add_sum;
      end
    end else if (step.mul_en) begin
      a_q <= a_q >> 1;
    end else if (step.div_en) begin
      if (divides) begin
        a_q <= {add_sum, a_q[alu_width-2:0], 1'b0};
      end else begin
        a_q <= {a_q[2*alu_width-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge step.clk) begin
    if (step.load) begin
      b_q <= i_b;
    end else if (step.flip_b_en) begin
      if (b_q[alu_width-1]) begin
        b_q <= add_sum;
      end
    end else if (step.mul_en) begin
      b_q <= b_q << 1;
    end
  end

  // Cleared on load, so a divide by zero reports zero
  always_ff @(posedge step.clk) begin
    if (step.load) begin
      result_q <= '0;
    end else if (step.add_en || step.sub_en || step.negate_en) begin
      result_q <= add_sum;
    end else if (step.mul_en) begin
      // Partial product added only for a set multiplier bit
      if (a_q[0]) begin
        result_q <= add_sum;
      end
    end else if (step.div_en) begin
      result_q <= {result_q[alu_width-2:0], divides};
    end
  end

  assign o_result = result_q;

  // New operands never arrive while a step is still working on the old ones
  a_load_alone: assert property (@(posedge step.clk) disable iff (!step.rst_n)
    step.load |-> !(step.add_en || step.sub_en || step.mul_en || step.div_en ||
                    step.flip_a_en || step.flip_b_en || step.negate_en));

endmodule

`default_nettype wire

// File: design/alu_sequencer.sv
// Control FSM of the ALU that runs the handshake and issues one data path strobe per cycle
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer (
  input  logic               i_in_valid,
  input  alu_pkg::alu_op_e   i_op,
  input  logic               i_signed,
  input  alu_pkg::alu_word_t i_a,
  input  alu_pkg::alu_word_t i_b,
  input  logic               i_out_ready,
  output logic               o_in_ready,
  output logic               o_out_valid,
  output logic               o_error,
  alu_step_if.ctrl           step
);
  import alu_pkg::*;

  typedef enum logic [3:0] {
    S_WAIT,
    S_ADD,
    S_SUB,
    S_MUL_INIT,
    S_MUL_RUN,
    S_FLIP_A,
    S_FLIP_B,
    S_DIV_INIT,
    S_DIV_RUN,
    S_DIV_POST,
    S_RESULT,
    S_ERROR
  } seq_state_e;

  seq_state_e               state;
  logic [alu_cnt_width-1:0] cnt;
  logic                     negate_q;
  logic                     accept;
  logic                     last_iter;

  assign accept    = i_in_valid && o_in_ready;
  assign last_iter = (cnt == '0);

  always_ff @(posedge step.clk or negedge step.rst_n) begin
    if (!step.rst_n) begin
      state    <= S_WAIT;
      negate_q <= 1'b0;
    end else begin
      case (state)
        S_WAIT: begin
          if (accept) begin
            case (i_op)
              OP_ADD: state <= S_ADD;
              OP_SUB: state <= S_SUB;
              OP_MUL: state <= S_MUL_INIT;
              OP_DIV: begin
                // Quotient is negative when signed operands differ in sign
                negate_q <= i_signed && (i_a[alu_width-1] ^ i_b[alu_width-1]);
                if (i_b == '0) begin
                  state <= S_ERROR;
                end else if (i_signed) begin
                  state <= S_FLIP_A;
                end else begin
                  state <= S_DIV_INIT;
                end
              end
              default: state <= S_WAIT;
            endcase
          end
        end
        S_ADD, S_SUB: state <= S_RESULT;
        S_MUL_INIT:   state <= S_MUL_RUN;
        S_MUL_RUN: begin
          if (last_iter) begin
            state <= S_RESULT;
          end
        end
        S_FLIP_A:   state <= S_FLIP_B;
        S_FLIP_B:   state <= S_DIV_INIT;
        S_DIV_INIT: state <= S_DIV_RUN;
        S_DIV_RUN: begin
          if (last_iter) begin
            state <= S_DIV_POST;
          end
        end
        S_DIV_POST: state <= S_RESULT;
        S_RESULT, S_ERROR: begin
          if (i_out_ready) begin
            state <= S_WAIT;
          end
        end
        default: state <= S_WAIT;
      endcase
    end
  end

  // Reloaded outside the run states, so each run gets alu_width iterations
  always_ff @(posedge step.clk or negedge step.rst_n) begin
    if (!step.rst_n) begin
      cnt <= alu_cnt_width'(alu_width - 1);
    end else if (state == S_MUL_RUN || state == S_DIV_RUN) begin
      cnt <= cnt - 1'b1;
    end else begin
      cnt <= alu_cnt_width'(alu_width - 1);
    end
  end

  assign o_in_ready  = (state == S_WAIT);
  assign o_out_valid = (state == S_RESULT) || (state == S_ERROR);
  assign o_error     = (state == S_ERROR);

  assign step.load      = accept;
  assign step.add_en    = (state == S_ADD);
  assign step.sub_en    = (state == S_SUB);
  assign step.mul_en    = (state == S_MUL_RUN);
  assign step.div_en    = (state == S_DIV_RUN);
  assign step.flip_a_en = (state == S_FLIP_A);
  assign step.flip_b_en = (state == S_FLIP_B);
  assign step.negate_en = (state == S_DIV_POST) && negate_q;

  // The shared adder serves one step at a time
  a_strobe_onehot: assert property (@(posedge step.clk) disable iff (!step.rst_n)
    $onehot0({step.add_en, step.sub_en, step.mul_en, step.div_en,
              step.flip_a_en, step.flip_b_en, step.negate_en}));

  // Result and error flag wait for the consumer
  a_valid_held: assert property (@(posedge step.clk) disable iff (!step.rst_n)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_error));

  // Input side reopens only on the edge after a result is taken
  a_ready_after_take: assert property (@(posedge step.clk) disable iff (!step.rst_n)
    $rose(o_in_ready) |-> $past(o_out_valid && i_out_ready));

endmodule

`default_nettype wire

// File: design/alu_step_if.sv
// Step strobes from the ALU sequencer to the data path with one data path action per clock edge
`timescale 1ns/1ps
`default_nettype none

interface alu_step_if (
  input logic clk,
  input logic rst_n
);

  // Accept operands on this edge
  logic load;

  // Step strobes, at most one high per cycle
  logic add_en;
  logic sub_en;
  logic mul_en;
  logic div_en;
  logic flip_a_en;
  logic flip_b_en;
  logic negate_en;

  modport ctrl (
    input  clk,
    input  rst_n,
    output load,
    output add_en,
    output sub_en,
    output mul_en,
    output div_en,
    output flip_a_en,
    output flip_b_en,
    output negate_en
  );

  modport dp (
    input clk,
    input rst_n,
    input load,
    input add_en,
    input sub_en,
    input mul_en,
    input div_en,
    input flip_a_en,
    input flip_b_en,
    input negate_en
  );

endinterface

`default_nettype wire

// File: design/alu_pkg.sv
// Widths, word type and operation codes for the multi-cycle ALU, imported by the RTL modules
`default_nettype none

package alu_pkg;

  // Operand and result width
  localparam int alu_width = 16;

  // Iteration counter for multiply and divide
  // Counts alu_width-1 down to 0
  localparam int alu_cnt_width = $clog2(alu_width);

  // One operand or result word
  typedef logic [alu_width-1:0] alu_word_t;

  // Operation select on i_op
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_DIV = 2'd3
  } alu_op_e;

endpackage

`default_nettype wire
